//--- include/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Instruction word and base integer width
`define RV_INSN_W 32
`define RV_XLEN 32

// Register file has 32 entries
`define RV_REG_IDX_W 5

// Exception cause field and the synchronous causes raised in decode
`define RV_CAUSE_W 4
`define RV_CAUSE_ILLEGAL 2
`define RV_CAUSE_BREAK 3
`define RV_CAUSE_ECALL 11

`endif

//--- source/rv_isa_pkg.sv
`default_nettype none

`include "rv_decode_config.svh"

package rv_isa_pkg;

    // Raw instruction word as fetched
    typedef logic [`RV_INSN_W-1:0] insn_t;

    // PC and data path word
    typedef logic [`RV_XLEN-1:0] xlen_t;

    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    // Exception cause code without the interrupt bit
    typedef logic [`RV_CAUSE_W-1:0] cause_t;

    // RV32I major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        OPCODE_LOAD     = 7'b0000011,
        OPCODE_MISC_MEM = 7'b0001111,
        OPCODE_OP_IMM   = 7'b0010011,
        OPCODE_AUIPC    = 7'b0010111,
        OPCODE_STORE    = 7'b0100011,
        OPCODE_OP       = 7'b0110011,
        OPCODE_LUI      = 7'b0110111,
        OPCODE_BRANCH   = 7'b1100011,
        OPCODE_JALR     = 7'b1100111,
        OPCODE_JAL      = 7'b1101111,
        OPCODE_SYSTEM   = 7'b1110011
    } opcode_e;

endpackage

`default_nettype wire

//--- source/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    // What the execute stage does with the instruction
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MEM_LOAD,
        OP_MEM_STORE,
        OP_BRANCH,
        OP_JALR,
        OP_AUIPC,
        OP_FENCE_I,
        OP_NOP
    } op_type_e;

    // ALU function, shifts are refined by the shift flags
    typedef enum logic [2:0] {
        ALU_ADDSUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SHIFT
    } alu_op_e;

    // Branch condition, JUMP is taken unconditionally
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU,
        CMP_JUMP
    } cmp_op_e;

    // Access size as log2 of bytes, straight from funct3[1:0]
    typedef logic [1:0] mem_size_t;

    // Immediate layout selected by the decoder
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  wire insn_t    i_insn,
    input  wire imm_fmt_e i_imm_fmt,
    output xlen_t         o_imm
);

    // Bit 31 is the sign for every format
    logic  sign;
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    assign sign = i_insn[31];

    assign imm_i = {{20{sign}}, i_insn[31:20]};
    assign imm_s = {{20{sign}}, i_insn[31:25], i_insn[11:7]};
    // Branch and jump offsets are in halfwords, low bit always zero
    assign imm_b = {{19{sign}}, sign, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{11{sign}}, sign, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    always_comb begin
        case (i_imm_fmt)
            IMM_I:   o_imm = imm_i;
            IMM_S:   o_imm = imm_s;
            IMM_B:   o_imm = imm_b;
            IMM_U:   o_imm = imm_u;
            IMM_J:   o_imm = imm_j;
            default: o_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module insn_decoder
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  wire insn_t  i_insn,
    input  wire xlen_t  i_pc,
    input  wire logic   i_fetch_fault,
    input  wire cause_t i_fetch_cause,
    output op_type_e    o_op_type,
    output alu_op_e     o_alu_op,
    output logic        o_alu_sub,
    output logic        o_shift_left,
    output logic        o_shift_arith,
    output cmp_op_e     o_cmp_op,
    output mem_size_t   o_mem_size,
    output logic        o_mem_zeroext,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output logic        o_use_imm,
    output imm_fmt_e    o_imm_fmt,
    output logic        o_exc_valid,
    output cause_t      o_exc_cause,
    output xlen_t       o_exc_tval
);

    opcode_e    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       illegal;
    logic       is_ecall;
    logic       is_ebreak;

    assign opcode = opcode_e'(i_insn[6:0]);
    assign funct7 = i_insn[31:25];
    assign funct3 = i_insn[14:12];

    always_comb begin
        o_op_type     = OP_NOP;
        o_alu_op      = ALU_ADDSUB;
        o_alu_sub     = 1'b0;
        o_shift_left  = 1'b0;
        o_shift_arith = 1'b0;
        o_cmp_op      = CMP_EQ;
        o_mem_size    = funct3[1:0];
        o_mem_zeroext = 1'b0;
        o_rs1         = '0;
        o_rs2         = '0;
        o_rd          = '0;
        o_use_imm     = 1'b0;
        o_imm_fmt     = IMM_NONE;
        illegal       = 1'b0;
        is_ecall      = 1'b0;
        is_ebreak     = 1'b0;

        case (opcode)
            OPCODE_LOAD: begin
                o_op_type     = OP_MEM_LOAD;
                o_rs1         = i_insn[19:15];
                o_rd          = i_insn[11:7];
                o_mem_zeroext = funct3[2];
                o_use_imm     = 1'b1;
                o_imm_fmt     = IMM_I;
                // No doubleword on RV32, and LWU does not exist
                illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            OPCODE_MISC_MEM: begin
                // FENCE is a NOP on this in-order core
                if (funct3 == 3'b001) begin
                    o_op_type = OP_FENCE_I;
                end else if (funct3 != 3'b000) begin
                    illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: begin
                o_op_type = OP_ALU;
                o_rs1     = i_insn[19:15];
                o_rd      = i_insn[11:7];
                o_use_imm = 1'b1;
                o_imm_fmt = IMM_I;
                case (funct3)
                    3'b000: o_alu_op = ALU_ADDSUB;
                    3'b010: begin
                        o_alu_op  = ALU_SLT;
                        o_alu_sub = 1'b1;
                    end
                    3'b011: begin
                        o_alu_op  = ALU_SLTU;
                        o_alu_sub = 1'b1;
                    end
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    3'b001: begin
                        o_alu_op     = ALU_SHIFT;
                        o_shift_left = 1'b1;
                        // shamt[5] is funct7 bit 0 and must be clear on RV32
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: begin
                        o_alu_op      = ALU_SHIFT;
                        o_shift_arith = funct7[5];
                        illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            OPCODE_AUIPC: begin
                o_op_type = OP_AUIPC;
                o_rd      = i_insn[11:7];
                o_use_imm = 1'b1;
                o_imm_fmt = IMM_U;
            end
            OPCODE_STORE: begin
                o_op_type = OP_MEM_STORE;
                o_rs1     = i_insn[19:15];
                o_rs2     = i_insn[24:20];
                o_use_imm = 1'b1;
                o_imm_fmt = IMM_S;
                illegal   = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OPCODE_OP: begin
                o_op_type = OP_ALU;
                o_rs1     = i_insn[19:15];
                o_rs2     = i_insn[24:20];
                o_rd      = i_insn[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_alu_op = ALU_ADDSUB;
                    {7'b0100000, 3'b000}: begin
                        o_alu_op  = ALU_ADDSUB;
                        o_alu_sub = 1'b1;
                    end
                    {7'b0000000, 3'b010}: begin
                        o_alu_op  = ALU_SLT;
                        o_alu_sub = 1'b1;
                    end
                    {7'b0000000, 3'b011}: begin
                        o_alu_op  = ALU_SLTU;
                        o_alu_sub = 1'b1;
                    end
                    {7'b0000000, 3'b100}: o_alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: o_alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: o_alu_op = ALU_AND;
                    {7'b0000000, 3'b001}: begin
                        o_alu_op     = ALU_SHIFT;
                        o_shift_left = 1'b1;
                    end
                    {7'b0000000, 3'b101}: o_alu_op = ALU_SHIFT;
                    {7'b0100000, 3'b101}: begin
                        o_alu_op      = ALU_SHIFT;
                        o_shift_arith = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPCODE_LUI: begin
                // Executed as x0 + imm
                o_op_type = OP_ALU;
                o_rd      = i_insn[11:7];
                o_use_imm = 1'b1;
                o_imm_fmt = IMM_U;
            end
            OPCODE_BRANCH: begin
                o_op_type = OP_BRANCH;
                o_rs1     = i_insn[19:15];
                o_rs2     = i_insn[24:20];
                o_alu_sub = 1'b1;
                o_imm_fmt = IMM_B;
                case (funct3)
                    3'b000:  o_cmp_op = CMP_EQ;
                    3'b001:  o_cmp_op = CMP_NE;
                    3'b100:  o_cmp_op = CMP_LT;
                    3'b101:  o_cmp_op = CMP_GE;
                    3'b110:  o_cmp_op = CMP_LTU;
                    3'b111:  o_cmp_op = CMP_GEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPCODE_JALR: begin
                o_op_type = OP_JALR;
                o_rs1     = i_insn[19:15];
                o_rd      = i_insn[11:7];
                o_use_imm = 1'b1;
                o_imm_fmt = IMM_I;
                illegal   = (funct3 != 3'b000);
            end
            OPCODE_JAL: begin
                o_op_type = OP_BRANCH;
                o_rd      = i_insn[11:7];
                o_cmp_op  = CMP_JUMP;
                o_imm_fmt = IMM_J;
            end
            OPCODE_SYSTEM: begin
                // Only the two exact environment call words are accepted
                if (i_insn[19:7] != '0) begin
                    illegal = 1'b1;
                end else if (i_insn[31:20] == 12'h000) begin
                    is_ecall = 1'b1;
                end else if (i_insn[31:20] == 12'h001) begin
                    is_ebreak = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    // Fetch fault has priority, the word itself may be garbage
    always_comb begin
        o_exc_valid = illegal || is_ecall || is_ebreak;
        o_exc_cause = cause_t'(`RV_CAUSE_ILLEGAL);
        o_exc_tval  = i_insn;
        if (is_ecall) begin
            o_exc_cause = cause_t'(`RV_CAUSE_ECALL);
            o_exc_tval  = '0;
        end else if (is_ebreak) begin
            o_exc_cause = cause_t'(`RV_CAUSE_BREAK);
            o_exc_tval  = '0;
        end
        if (i_fetch_fault) begin
            o_exc_valid = 1'b1;
            o_exc_cause = i_fetch_cause;
            o_exc_tval  = i_pc;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg #(
    parameter int DATA_W = 8
) (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic              i_valid,
    output logic                   o_ready,
    input  wire logic [DATA_W-1:0] i_data,
    output logic                   o_valid,
    input  wire logic              i_ready,
    output logic [DATA_W-1:0]      o_data
);

    logic accept;

    // Upstream may push whenever downstream can drain, even into an empty slot.
    // The slot is never left holding an item that cannot leave.
    assign o_ready = i_ready;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (o_valid && i_ready) begin
            // Item left and nothing replaced it
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_data <= i_data;
        end
    end

    // Valid must be a clean level once out of reset
    a_valid_known: assert property (
        @(posedge clk) disable iff (!resetn)
        !$isunknown(o_valid)
    );

    // A stalled item stays put until downstream takes it
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!resetn)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
    );

endmodule

`default_nettype wire

//--- source/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetn,
    input  wire logic   i_valid,
    input  wire insn_t  i_insn,
    input  wire xlen_t  i_pc,
    input  wire logic   i_fetch_fault,
    input  wire cause_t i_fetch_cause,
    input  wire logic   i_ready_out,
    output logic        o_ready,
    output logic        o_valid,
    output op_type_e    o_op_type,
    output alu_op_e     o_alu_op,
    output logic        o_alu_sub,
    output logic        o_shift_left,
    output logic        o_shift_arith,
    output cmp_op_e     o_cmp_op,
    output mem_size_t   o_mem_size,
    output logic        o_mem_zeroext,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output logic        o_use_imm,
    output xlen_t       o_imm,
    output xlen_t       o_pc,
    output logic        o_exc_valid,
    output cause_t      o_exc_cause,
    output xlen_t       o_exc_tval
);

    localparam int DEC_W = 3 * $bits(op_type_e) + 6 + $bits(mem_size_t)
                         + 3 * $bits(reg_idx_t) + 3 * $bits(xlen_t) + $bits(cause_t);

    op_type_e   dec_op_type;
    alu_op_e    dec_alu_op;
    logic       dec_alu_sub;
    logic       dec_shift_left;
    logic       dec_shift_arith;
    cmp_op_e    dec_cmp_op;
    mem_size_t  dec_mem_size;
    logic       dec_mem_zeroext;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    reg_idx_t   dec_rd;
    logic       dec_use_imm;
    imm_fmt_e   dec_imm_fmt;
    xlen_t      dec_imm;
    logic       dec_exc_valid;
    cause_t     dec_exc_cause;
    xlen_t      dec_exc_tval;
    logic [DEC_W-1:0] stage_d;
    logic [DEC_W-1:0] stage_q;
    logic [2:0] q_op_type;
    logic [2:0] q_alu_op;
    logic [2:0] q_cmp_op;

    insn_decoder u_decoder (
        .i_insn        (i_insn),
        .i_pc          (i_pc),
        .i_fetch_fault (i_fetch_fault),
        .i_fetch_cause (i_fetch_cause),
        .o_op_type     (dec_op_type),
        .o_alu_op      (dec_alu_op),
        .o_alu_sub     (dec_alu_sub),
        .o_shift_left  (dec_shift_left),
        .o_shift_arith (dec_shift_arith),
        .o_cmp_op      (dec_cmp_op),
        .o_mem_size    (dec_mem_size),
        .o_mem_zeroext (dec_mem_zeroext),
        .o_rs1         (dec_rs1),
        .o_rs2         (dec_rs2),
        .o_rd          (dec_rd),
        .o_use_imm     (dec_use_imm),
        .o_imm_fmt     (dec_imm_fmt),
        .o_exc_valid   (dec_exc_valid),
        .o_exc_cause   (dec_exc_cause),
        .o_exc_tval    (dec_exc_tval)
    );

    imm_gen u_imm_gen (
        .i_insn    (i_insn),
        .i_imm_fmt (dec_imm_fmt),
        .o_imm     (dec_imm)
    );

    // Field order here and in the unpacking below must match
    assign stage_d = {dec_op_type, dec_alu_op, dec_alu_sub, dec_shift_left, dec_shift_arith,
                      dec_cmp_op, dec_mem_size, dec_mem_zeroext, dec_rs1, dec_rs2, dec_rd,
                      dec_use_imm, dec_imm, i_pc, dec_exc_valid, dec_exc_cause,
                      dec_exc_tval};

    decode_stage_reg #(
        .DATA_W (DEC_W)
    ) u_stage (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (stage_d),
        .o_valid (o_valid),
        .i_ready (i_ready_out),
        .o_data  (stage_q)
    );

    assign {q_op_type, q_alu_op, o_alu_sub, o_shift_left, o_shift_arith,
            q_cmp_op, o_mem_size, o_mem_zeroext, o_rs1, o_rs2, o_rd,
            o_use_imm, o_imm, o_pc, o_exc_valid, o_exc_cause, o_exc_tval} = stage_q;

    assign o_op_type = op_type_e'(q_op_type);
    assign o_alu_op  = alu_op_e'(q_alu_op);
    assign o_cmp_op  = cmp_op_e'(q_cmp_op);

endmodule

`default_nettype wire

//--- tb/tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module tb_rv_decode
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;
();

    // Which field groups an entry compares beyond PC and exception
    localparam logic [3:0] M_NONE     = 4'b0000;
    localparam logic [3:0] M_ALU      = 4'b0001;
    localparam logic [3:0] M_MEM      = 4'b0010;
    localparam logic [3:0] M_BR       = 4'b0100;
    localparam logic [3:0] M_EXC_ONLY = 4'b1000;

    typedef struct packed {
        insn_t      insn;
        xlen_t      pc;
        logic       fault;
        cause_t     fcause;
        logic [3:0] mask;
        op_type_e   op;
        alu_op_e    alu;
        logic       sub;
        logic       shl;
        logic       sha;
        cmp_op_e    cmp;
        mem_size_t  size;
        logic       zext;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       use_imm;
        xlen_t      imm;
        logic       exc;
        cause_t     cause;
        xlen_t      tval;
    } entry_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        i_valid;
    insn_t       i_insn;
    xlen_t       i_pc;
    logic        i_fetch_fault;
    cause_t      i_fetch_cause;
    logic        i_ready_out;
    logic        o_ready;
    logic        o_valid;
    op_type_e    o_op_type;
    alu_op_e     o_alu_op;
    logic        o_alu_sub;
    logic        o_shift_left;
    logic        o_shift_arith;
    cmp_op_e     o_cmp_op;
    mem_size_t   o_mem_size;
    logic        o_mem_zeroext;
    reg_idx_t    o_rs1;
    reg_idx_t    o_rs2;
    reg_idx_t    o_rd;
    logic        o_use_imm;
    xlen_t       o_imm;
    xlen_t       o_pc;
    logic        o_exc_valid;
    cause_t      o_exc_cause;
    xlen_t       o_exc_tval;

    entry_t       table_q[$];
    int           exp_q[$];
    int           send_idx = 0;
    int           done_count = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    int           error_count = 0;
    integer       seed = 24702;
    logic [31:0]  rnd;
    logic         table_ready = 1'b0;
    logic         after_reset = 1'b0;
    logic         stalled = 1'b0;
    logic         accepted_prev = 1'b0;
    logic [255:0] held = '0;

    rv_decode dut (
        .clk           (clk),
        .resetn        (resetn),
        .i_valid       (i_valid),
        .i_insn        (i_insn),
        .i_pc          (i_pc),
        .i_fetch_fault (i_fetch_fault),
        .i_fetch_cause (i_fetch_cause),
        .i_ready_out   (i_ready_out),
        .o_ready       (o_ready),
        .o_valid       (o_valid),
        .o_op_type     (o_op_type),
        .o_alu_op      (o_alu_op),
        .o_alu_sub     (o_alu_sub),
        .o_shift_left  (o_shift_left),
        .o_shift_arith (o_shift_arith),
        .o_cmp_op      (o_cmp_op),
        .o_mem_size    (o_mem_size),
        .o_mem_zeroext (o_mem_zeroext),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_use_imm     (o_use_imm),
        .o_imm         (o_imm),
        .o_pc          (o_pc),
        .o_exc_valid   (o_exc_valid),
        .o_exc_cause   (o_exc_cause),
        .o_exc_tval    (o_exc_tval)
    );

    always #20 clk = ~clk;

    function automatic xlen_t table_pc();
        table_pc = 32'h0000_1000 + 32'(4 * table_q.size());
    endfunction

    function automatic logic [255:0] out_vec();
        out_vec = {o_valid, o_op_type, o_alu_op, o_alu_sub, o_shift_left, o_shift_arith,
                   o_cmp_op, o_mem_size, o_mem_zeroext, o_rs1, o_rs2, o_rd, o_use_imm,
                   o_imm, o_pc, o_exc_valid, o_exc_cause, o_exc_tval};
    endfunction

    task automatic add_legal(
        input insn_t      insn,
        input logic [3:0] mask,
        input op_type_e   op,
        input alu_op_e    alu,
        input logic       sub,
        input logic       shl,
        input logic       sha,
        input cmp_op_e    cmp,
        input mem_size_t  size,
        input logic       zext,
        input reg_idx_t   rs1,
        input reg_idx_t   rs2,
        input reg_idx_t   rd,
        input logic       use_imm,
        input xlen_t      imm
    );
        entry_t e;
        e         = '0;
        e.insn    = insn;
        e.pc      = table_pc();
        e.mask    = mask;
        e.op      = op;
        e.alu     = alu;
        e.sub     = sub;
        e.shl     = shl;
        e.sha     = sha;
        e.cmp     = cmp;
        e.size    = size;
        e.zext    = zext;
        e.rs1     = rs1;
        e.rs2     = rs2;
        e.rd      = rd;
        e.use_imm = use_imm;
        e.imm     = imm;
        table_q.push_back(e);
    endtask

    task automatic add_trap(
        input insn_t  insn,
        input xlen_t  pc,
        input logic   fault,
        input cause_t fcause,
        input cause_t cause,
        input xlen_t  tval
    );
        entry_t e;
        e        = '0;
        e.insn   = insn;
        e.pc     = pc;
        e.fault  = fault;
        e.fcause = fcause;
        e.mask   = M_EXC_ONLY;
        e.exc    = 1'b1;
        e.cause  = cause;
        e.tval   = tval;
        table_q.push_back(e);
    endtask

    // Illegal words trap with their own encoding as trap value
    task automatic add_illegal(input insn_t insn);
        add_trap(insn, table_pc(), 1'b0, 4'h0, `RV_CAUSE_ILLEGAL, insn);
    endtask

    task automatic build_table();
        // Column order is insn, mask, op, alu, sub, shl, sha, cmp, size, zext,
        // then rs1, rs2, rd, use_imm and imm
        add_legal(32'h002081B3, M_ALU, OP_ALU, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd1, 5'd2, 5'd3, 1'b0, 32'h0000_0000);
        add_legal(32'h407302B3, M_ALU, OP_ALU, ALU_ADDSUB, 1'b1, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd6, 5'd7, 5'd5, 1'b0, 32'h0000_0000);
        add_legal(32'h00C5A533, M_ALU, OP_ALU, ALU_SLT, 1'b1, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd11, 5'd12, 5'd10, 1'b0, 32'h0000_0000);
        add_legal(32'hFFF2B213, M_ALU, OP_ALU, ALU_SLTU, 1'b1, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd5, 5'd0, 5'd4, 1'b1, 32'hFFFF_FFFF);
        add_legal(32'h7FF4C413, M_ALU, OP_ALU, ALU_XOR, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd9, 5'd0, 5'd8, 1'b1, 32'h0000_07FF);
        add_legal(32'h01F11093, M_ALU, OP_ALU, ALU_SHIFT, 1'b0, 1'b1, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd2, 5'd0, 5'd1, 1'b1, 32'h0000_001F);
        add_legal(32'h0041D113, M_ALU, OP_ALU, ALU_SHIFT, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd3, 5'd0, 5'd2, 1'b1, 32'h0000_0004);
        add_legal(32'h4041D113, M_ALU, OP_ALU, ALU_SHIFT, 1'b0, 1'b0, 1'b1, CMP_EQ,
                  2'd0, 1'b0, 5'd3, 5'd0, 5'd2, 1'b1, 32'h0000_0404);
        add_legal(32'h40F756B3, M_ALU, OP_ALU, ALU_SHIFT, 1'b0, 1'b0, 1'b1, CMP_EQ,
                  2'd0, 1'b0, 5'd14, 5'd15, 5'd13, 1'b0, 32'h0000_0000);
        // Loads, stores, branches, jumps and upper immediates
        add_legal(32'hFFC3A303, M_MEM, OP_MEM_LOAD, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd2, 1'b0, 5'd7, 5'd0, 5'd6, 1'b1, 32'hFFFF_FFFC);
        add_legal(32'h01014083, M_MEM, OP_MEM_LOAD, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b1, 5'd2, 5'd0, 5'd1, 1'b1, 32'h0000_0010);
        add_legal(32'hFE952C23, M_MEM, OP_MEM_STORE, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd2, 1'b0, 5'd10, 5'd9, 5'd0, 1'b1, 32'hFFFF_FFF8);
        add_legal(32'h022182A3, M_MEM, OP_MEM_STORE, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd3, 5'd2, 5'd0, 1'b1, 32'h0000_0025);
        add_legal(32'hFE2088E3, M_BR, OP_BRANCH, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd1, 5'd2, 5'd0, 1'b0, 32'hFFFF_FFF0);
        add_legal(32'h0062E0E3, M_BR, OP_BRANCH, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_LTU,
                  2'd0, 1'b0, 5'd5, 5'd6, 5'd0, 1'b0, 32'h0000_0800);
        add_legal(32'h801FF0EF, M_BR, OP_BRANCH, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_JUMP,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd1, 1'b0, 32'hFFFF_F800);
        add_legal(32'h346122EF, M_BR, OP_BRANCH, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_JUMP,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd5, 1'b0, 32'h0001_2346);
        add_legal(32'hFFF280E7, M_NONE, OP_JALR, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd5, 5'd0, 5'd1, 1'b1, 32'hFFFF_FFFF);
        add_legal(32'hABCDE3B7, M_NONE, OP_ALU, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd7, 1'b1, 32'hABCD_E000);
        add_legal(32'h12345117, M_NONE, OP_AUIPC, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd2, 1'b1, 32'h1234_5000);
        // FENCE retires as a NOP and FENCE.I has its own class
        add_legal(32'h0FF0000F, M_NONE, OP_NOP, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h0000_0000);
        add_legal(32'h0000100F, M_NONE, OP_FENCE_I, ALU_ADDSUB, 1'b0, 1'b0, 1'b0, CMP_EQ,
                  2'd0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h0000_0000);
        add_illegal(32'h00013083);
        add_illegal(32'h00016083);
        add_illegal(32'h00017083);
        add_illegal(32'h0221C2A3);
        add_illegal(32'h0221B2A3);
        add_illegal(32'h02011093);
        add_illegal(32'h2041D113);
        add_illegal(32'h022081B3);
        add_illegal(32'h402091B3);
        add_illegal(32'h0020A063);
        add_illegal(32'h0020B063);
        add_illegal(32'h000090E7);
        add_illegal(32'h0000200F);
        add_illegal(32'h30011073);
        add_illegal(32'h10500073);
        add_illegal(32'h30200073);
        add_illegal(32'h0000001B);
        add_illegal(32'h00000000);
        // Environment calls trap with a zero trap value
        add_trap(32'h00000073, table_pc(), 1'b0, 4'h0, `RV_CAUSE_ECALL, 32'h0000_0000);
        add_trap(32'h00100073, table_pc(), 1'b0, 4'h0, `RV_CAUSE_BREAK, 32'h0000_0000);
        // Fetch fault wins over whatever the word decodes to
        add_trap(32'h002081B3, 32'h8000_0040, 1'b1, 4'h1, 4'h1, 32'h8000_0040);
        add_trap(32'h00000073, 32'h8000_1FFC, 1'b1, 4'hC, 4'hC, 32'h8000_1FFC);
        add_trap(32'h00000000, 32'h0000_2468, 1'b1, 4'h0, 4'h0, 32'h0000_2468);
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_entry(input int idx);
        entry_t e;
        int     errs_before;
        e           = table_q[idx];
        errs_before = error_count;
        check_value("o_pc", o_pc, e.pc);
        check_value("o_exc_valid", o_exc_valid, e.exc);
        if (e.exc) begin
            check_value("o_exc_cause", o_exc_cause, e.cause);
            check_value("o_exc_tval", o_exc_tval, e.tval);
        end
        if (!e.mask[3]) begin
            check_value("o_op_type", o_op_type, e.op);
            check_value("o_rs1", o_rs1, e.rs1);
            check_value("o_rs2", o_rs2, e.rs2);
            check_value("o_rd", o_rd, e.rd);
            check_value("o_use_imm", o_use_imm, e.use_imm);
            check_value("o_imm", o_imm, e.imm);
        end
        if (e.mask[0]) begin
            check_value("o_alu_op", o_alu_op, e.alu);
            check_value("o_alu_sub", o_alu_sub, e.sub);
            check_value("o_shift_left", o_shift_left, e.shl);
            check_value("o_shift_arith", o_shift_arith, e.sha);
        end
        if (e.mask[1]) begin
            check_value("o_mem_size", o_mem_size, e.size);
            check_value("o_mem_zeroext", o_mem_zeroext, e.zext);
        end
        if (e.mask[2]) begin
            check_value("o_cmp_op", o_cmp_op, e.cmp);
        end
        if (error_count == errs_before) begin
            pass_count++;
            $display("Entry %0d insn 0x%08h ok", idx, e.insn);
        end else begin
            fail_count++;
            $display("Entry %0d insn 0x%08h mismatch", idx, e.insn);
        end
    endtask

    // Monitor and driver share one edge so acceptance is seen identically by both
    always @(posedge clk) begin
        if (!resetn) begin
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_value("o_valid after reset", o_valid, 32'd0);
                after_reset = 1'b0;
            end
            check_value("o_ready", o_ready, i_ready_out);
            if (stalled && (out_vec() !== held)) begin
                error_count++;
                $display("Error: outputs changed while the stage was stalled");
            end
            if (accepted_prev && !o_valid) begin
                error_count++;
                $display("Error: accepted entry did not reach the outputs one cycle later");
            end
            if (o_valid && i_ready_out) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Error: output transfer with no accepted entry pending");
                end else begin
                    compare_entry(exp_q.pop_front());
                    done_count++;
                end
            end
            stalled       = o_valid && !i_ready_out;
            held          = out_vec();
            accepted_prev = i_valid && o_ready;
            if (i_valid && o_ready) begin
                exp_q.push_back(send_idx);
                send_idx++;
            end
            rnd = $random(seed);
            i_ready_out <= rnd[0];
            if (send_idx < table_q.size()) begin
                i_valid       <= 1'b1;
                i_insn        <= table_q[send_idx].insn;
                i_pc          <= table_q[send_idx].pc;
                i_fetch_fault <= table_q[send_idx].fault;
                i_fetch_cause <= table_q[send_idx].fcause;
            end else begin
                i_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (table_q.size() * 20 + 4) @(posedge clk);
        $display("Timeout: handshake stalled with %0d of %0d entries checked",
                 done_count, table_q.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        resetn        = 1'b0;
        i_valid       = 1'b0;
        i_insn        = '0;
        i_pc          = '0;
        i_fetch_fault = 1'b0;
        i_fetch_cause = '0;
        i_ready_out   = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        wait (done_count == table_q.size());
        // One more monitored edge catches a stray transfer after the last entry
        repeat (2) @(negedge clk);
        $display("Entries: %0d passed, %0d failed, %0d errors in total",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_decode.f
+incdir+include
source/rv_isa_pkg.sv
source/decode_ctrl_pkg.sv
source/imm_gen.sv
source/insn_decoder.sv
source/decode_stage_reg.sv
source/rv_decode.sv
tb/tb_rv_decode.sv

//--- Bender.yml
package:
  name: rv_decode

export_include_dirs:
  - include

sources:
  - source/rv_isa_pkg.sv
  - source/decode_ctrl_pkg.sv
  - source/imm_gen.sv
  - source/insn_decoder.sv
  - source/decode_stage_reg.sv
  - source/rv_decode.sv
  - target: test
    files:
      - tb/tb_rv_decode.sv
